//--- rtl/conv_config.svh
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

// feature map and kernel geometry
`define CONV_FM_DIM      8
`define CONV_WT_DIM      3
`define CONV_OFM_DIM     6

// datapath and memory
`define CONV_DWIDTH      32
`define CONV_AWIDTH      10
`define CONV_MEM_DEPTH   1024

// register indices, register region
`define CONV_REG_CTRL    0   // bit 0 start, bit 1 soft reset
`define CONV_REG_STATUS  1   // bit 0 idle, bit 1 done
`define CONV_REG_WT_OFS  2
`define CONV_REG_IFM_OFS 3
`define CONV_REG_OFM_OFS 4

`endif

//--- rtl/conv_pkg.sv
`include "conv_config.svh"

package conv_pkg;

    typedef enum logic [1:0] {
        HOST_NOP,
        HOST_WRITE,
        HOST_READ
    } host_op_e;

    typedef struct packed {
        host_op_e                op;
        logic                    region;  // 1 register, 0 memory
        logic [`CONV_AWIDTH-1:0] addr;
        logic [`CONV_DWIDTH-1:0] wdata;
    } host_req_t;

    typedef struct packed {
        logic                    rvalid;
        logic [`CONV_DWIDTH-1:0] rdata;
    } host_rsp_t;

    typedef struct packed {
        logic                    en;
        logic                    we;
        logic [`CONV_AWIDTH-1:0] addr;
        logic [`CONV_DWIDTH-1:0] wdata;
    } mem_port_t;

    typedef struct packed {
        logic [`CONV_AWIDTH-1:0] wt_ofs;
        logic [`CONV_AWIDTH-1:0] ifm_ofs;
        logic [`CONV_AWIDTH-1:0] ofm_ofs;
    } conv_cfg_t;

    typedef struct packed {
        logic                    valid;
        logic [3:0]              tap;    // 0 to 8, row-major in the kernel
        logic [`CONV_DWIDTH-1:0] data;
    } tap_t;

    typedef enum logic {
        FETCH_IDLE,
        FETCH_RUN
    } fetch_state_e;

    typedef enum logic [1:0] {
        MAC_IDLE,
        MAC_RUN,
        MAC_DONE
    } mac_state_e;

endpackage

//--- rtl/conv_regs.sv
`include "conv_config.svh"

module conv_regs (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  conv_pkg::host_req_t     host_req_i,
    output conv_pkg::host_rsp_t     host_rsp_o,
    input  logic [`CONV_DWIDTH-1:0] mem_rdata_i,
    input  logic                    done_i,
    input  logic                    busy_i,
    output conv_pkg::conv_cfg_t     cfg_o,
    output logic                    start_o,
    output logic                    soft_reset_o,
    output conv_pkg::mem_port_t     host_mem_o
);
    import conv_pkg::*;

    logic                    locked;
    logic                    reg_wr;
    logic                    reg_rd;
    logic                    ctrl_wr;
    logic                    mem_req;
    logic                    rvalid_q;
    logic                    rd_mem_q;
    logic                    done_q;
    logic [`CONV_DWIDTH-1:0] reg_rdata;
    logic [`CONV_DWIDTH-1:0] reg_rdata_q;

    assign locked  = busy_i || start_o;  // engine owns config and port A
    assign reg_wr  = host_req_i.op == HOST_WRITE && host_req_i.region;
    assign reg_rd  = host_req_i.op == HOST_READ && host_req_i.region;
    assign ctrl_wr = reg_wr && host_req_i.addr == `CONV_REG_CTRL;
    assign mem_req = host_req_i.op != HOST_NOP && !host_req_i.region && !locked;

    assign host_mem_o = '{en: mem_req, we: host_req_i.op == HOST_WRITE,
                          addr: host_req_i.addr, wdata: host_req_i.wdata};

    // memory word comes straight from the RAM output register
    assign host_rsp_o = '{rvalid: rvalid_q, rdata: rd_mem_q ? mem_rdata_i : reg_rdata_q};

    always_comb begin
        case (host_req_i.addr)
            `CONV_REG_STATUS:  reg_rdata = {{(`CONV_DWIDTH-2){1'b0}}, done_q, ~busy_i};
            `CONV_REG_WT_OFS:  reg_rdata = `CONV_DWIDTH'(cfg_o.wt_ofs);
            `CONV_REG_IFM_OFS: reg_rdata = `CONV_DWIDTH'(cfg_o.ifm_ofs);
            `CONV_REG_OFM_OFS: reg_rdata = `CONV_DWIDTH'(cfg_o.ofm_ofs);
            default:           reg_rdata = '0;  // ctrl reads as zero
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cfg_o        <= '0;
            start_o      <= 1'b0;
            soft_reset_o <= 1'b0;
            rvalid_q     <= 1'b0;
            rd_mem_q     <= 1'b0;
            done_q       <= 1'b0;
        end else begin
            start_o      <= ctrl_wr && host_req_i.wdata[0] && !host_req_i.wdata[1] && !locked;
            soft_reset_o <= ctrl_wr && host_req_i.wdata[1];
            rvalid_q     <= host_req_i.op == HOST_READ;  // dropped reads answer zero
            rd_mem_q     <= mem_req && host_req_i.op == HOST_READ;
            if (reg_wr && !locked) begin
                case (host_req_i.addr)
                    `CONV_REG_WT_OFS:  cfg_o.wt_ofs  <= host_req_i.wdata[`CONV_AWIDTH-1:0];
                    `CONV_REG_IFM_OFS: cfg_o.ifm_ofs <= host_req_i.wdata[`CONV_AWIDTH-1:0];
                    `CONV_REG_OFM_OFS: cfg_o.ofm_ofs <= host_req_i.wdata[`CONV_AWIDTH-1:0];
                    default: ;
                endcase
            end
            if (start_o || soft_reset_o) begin
                done_q <= 1'b0;
            end else if (done_i) begin
                done_q <= 1'b1;  // sticky until next run
            end
        end
    end

    always_ff @(posedge clk_i) begin
        reg_rdata_q <= reg_rd ? reg_rdata : '0;
    end

    // a run only starts from idle, and the fetcher picks it up on the next cycle
    assert property (@(posedge clk_i) disable iff (reset_i)
        start_o |-> !busy_i ##1 busy_i)
        else $error("start strobe while the engine is busy");

endmodule

//--- rtl/conv_dmem.sv
`include "conv_config.svh"

module conv_dmem (
    input  logic                    clk_i,
    input  conv_pkg::mem_port_t     host_a_i,
    input  conv_pkg::mem_port_t     eng_a_i,
    input  logic                    busy_i,
    input  conv_pkg::mem_port_t     port_b_i,
    output logic [`CONV_DWIDTH-1:0] rdata_a_o,
    output logic [`CONV_DWIDTH-1:0] rdata_b_o
);
    import conv_pkg::*;

    logic [`CONV_DWIDTH-1:0] mem [`CONV_MEM_DEPTH];
    mem_port_t               port_a;

    assign port_a = busy_i ? eng_a_i : host_a_i;  // host only while idle

    always_ff @(posedge clk_i) begin
        if (port_a.en) begin
            if (port_a.we) begin
                mem[port_a.addr] <= port_a.wdata;
            end
            rdata_a_o <= mem[port_a.addr];  // read-first
        end
        if (port_b_i.en) begin
            if (port_b_i.we) begin
                mem[port_b_i.addr] <= port_b_i.wdata;
            end
            rdata_b_o <= mem[port_b_i.addr];
        end
    end

    // fetcher must raise busy before touching port A
    assert property (@(posedge clk_i) eng_a_i.en |-> busy_i)
        else $error("engine request on port A while idle");

endmodule

//--- rtl/weight_loader.sv
`include "conv_config.svh"

module weight_loader (
    input  logic                                                 clk_i,
    input  logic                                                 reset_i,
    input  logic                                                 start_i,
    input  conv_pkg::conv_cfg_t                                  cfg_i,
    input  logic [`CONV_DWIDTH-1:0]                              rdata_i,
    output conv_pkg::mem_port_t                                  rd_port_o,
    output logic [`CONV_WT_DIM*`CONV_WT_DIM-1:0][`CONV_DWIDTH-1:0] weights_o,
    output logic [`CONV_WT_DIM*`CONV_WT_DIM-1:0]                 wt_valid_o
);
    import conv_pkg::*;

    localparam int NTAPS = `CONV_WT_DIM * `CONV_WT_DIM;

    logic                             active;
    logic [3:0]                       cnt;
    logic                             pend_valid;
    logic [3:0]                       pend_idx;
    logic [NTAPS-1:0][`CONV_DWIDTH-1:0] wt_q;
    logic [NTAPS-1:0]                 valid_q;
    tap_t                             wt_tap;

    assign rd_port_o = '{en: active, we: 1'b0,
                         addr: cfg_i.wt_ofs + `CONV_AWIDTH'(cnt), wdata: '0};
    assign wt_tap    = '{valid: pend_valid, tap: pend_idx, data: rdata_i};

    // the word arriving this cycle bypasses its slot so it meets its pixel
    always_comb begin
        weights_o = wt_q;
        if (wt_tap.valid) begin
            weights_o[wt_tap.tap] = wt_tap.data;
        end
    end

    assign wt_valid_o = valid_q | (NTAPS'(wt_tap.valid) << wt_tap.tap);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            active     <= 1'b0;
            cnt        <= '0;
            pend_valid <= 1'b0;
            valid_q    <= '0;
        end else begin
            pend_valid <= active;
            if (start_i) begin
                active  <= 1'b1;
                cnt     <= '0;
                valid_q <= '0;  // new run, new kernel
            end else if (active) begin
                cnt <= cnt + 1'b1;
                if (cnt == NTAPS - 1) begin
                    active <= 1'b0;  // port B free for the MAC
                end
            end
            if (wt_tap.valid) begin
                valid_q[wt_tap.tap] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        pend_idx <= cnt;
        if (wt_tap.valid) begin
            wt_q[wt_tap.tap] <= wt_tap.data;
        end
    end

endmodule

//--- rtl/window_fetch.sv
`include "conv_config.svh"

module window_fetch (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    start_i,
    input  conv_pkg::conv_cfg_t     cfg_i,
    input  logic [`CONV_DWIDTH-1:0] rdata_i,
    output conv_pkg::mem_port_t     rd_port_o,
    output conv_pkg::tap_t          tap_o,
    output logic                    busy_o
);
    import conv_pkg::*;

    localparam int LAST_POS = `CONV_OFM_DIM - 1;
    localparam int LAST_K   = `CONV_WT_DIM - 1;

    fetch_state_e            state;
    logic                    run;
    logic [2:0]              row;
    logic [2:0]              col;
    logic [1:0]              ki;
    logic [1:0]              kj;
    logic [`CONV_AWIDTH-1:0] rd_addr;
    logic [3:0]              tap_idx;
    logic                    pend_valid;
    logic [3:0]              pend_tap;

    assign run     = state == FETCH_RUN;
    assign rd_addr = cfg_i.ifm_ofs
                   + `CONV_AWIDTH'((row + ki) * `CONV_FM_DIM + col + kj);  // row-major
    assign tap_idx = 4'(ki * `CONV_WT_DIM + kj);

    assign rd_port_o = '{en: run, we: 1'b0, addr: rd_addr, wdata: '0};
    assign tap_o     = '{valid: pend_valid, tap: pend_tap, data: rdata_i};
    assign busy_o    = run || pend_valid;  // until the last pixel is out

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state      <= FETCH_IDLE;
            row        <= '0;
            col        <= '0;
            ki         <= '0;
            kj         <= '0;
            pend_valid <= 1'b0;
        end else begin
            pend_valid <= run;
            case (state)
                FETCH_IDLE: begin
                    if (start_i) begin
                        state <= FETCH_RUN;  // counters already wrapped to zero
                    end
                end
                FETCH_RUN: begin
                    kj <= (kj == LAST_K) ? '0 : kj + 1'b1;
                    if (kj == LAST_K) begin
                        ki <= (ki == LAST_K) ? '0 : ki + 1'b1;
                        if (ki == LAST_K) begin  // window complete
                            col <= (col == LAST_POS) ? '0 : col + 1'b1;
                            if (col == LAST_POS) begin
                                row <= (row == LAST_POS) ? '0 : row + 1'b1;
                                if (row == LAST_POS) begin
                                    state <= FETCH_IDLE;
                                end
                            end
                        end
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        pend_tap <= tap_idx;
    end

endmodule

//--- rtl/conv_mac.sv
`include "conv_config.svh"

module conv_mac (
    input  logic                                                 clk_i,
    input  logic                                                 reset_i,
    input  logic                                                 start_i,
    input  conv_pkg::conv_cfg_t                                  cfg_i,
    input  conv_pkg::tap_t                                       tap_i,
    input  logic [`CONV_WT_DIM*`CONV_WT_DIM-1:0][`CONV_DWIDTH-1:0] weights_i,
    input  logic [`CONV_WT_DIM*`CONV_WT_DIM-1:0]                 wt_valid_i,
    output conv_pkg::mem_port_t                                  wr_port_o,
    output logic                                                 done_o
);
    import conv_pkg::*;

    localparam int NOUT     = `CONV_OFM_DIM * `CONV_OFM_DIM;
    localparam int LAST_TAP = `CONV_WT_DIM * `CONV_WT_DIM - 1;

    mac_state_e              state;
    logic [5:0]              out_idx;
    logic                    last_tap;
    logic [`CONV_DWIDTH-1:0] acc_q;
    logic [`CONV_DWIDTH-1:0] sum;
    logic                    wr_en_q;
    logic [`CONV_AWIDTH-1:0] wr_addr_q;
    logic [`CONV_DWIDTH-1:0] wr_data_q;
    logic                    done_q;

    assign last_tap = tap_i.valid && tap_i.tap == LAST_TAP;

    // low word of the product is the same for signed and unsigned operands
    assign sum = (tap_i.tap == 0 ? '0 : acc_q) + tap_i.data * weights_i[tap_i.tap];

    assign wr_port_o = '{en: wr_en_q, we: 1'b1, addr: wr_addr_q, wdata: wr_data_q};
    assign done_o    = done_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state   <= MAC_IDLE;
            out_idx <= '0;
            wr_en_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            wr_en_q <= state == MAC_RUN && last_tap;
            done_q  <= state == MAC_DONE;  // one cycle behind the last write
            case (state)
                MAC_IDLE: begin
                    if (start_i) begin
                        state   <= MAC_RUN;
                        out_idx <= '0;
                    end
                end
                MAC_RUN: begin
                    if (last_tap) begin
                        out_idx <= out_idx + 1'b1;
                        if (out_idx == NOUT - 1) begin
                            state <= MAC_DONE;
                        end
                    end
                end
                MAC_DONE: state <= MAC_IDLE;  // last write goes out here
                default:  state <= MAC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (tap_i.valid) begin
            acc_q <= sum;
        end
        wr_addr_q <= cfg_i.ofm_ofs + `CONV_AWIDTH'(out_idx);
        wr_data_q <= sum;
    end

    // loader and fetcher start together, so each pixel finds its weight
    assert property (@(posedge clk_i) disable iff (reset_i)
        tap_i.valid |-> wt_valid_i[tap_i.tap])
        else $error("tap %0d arrived before its weight", tap_i.tap);

endmodule

//--- rtl/conv_top.sv
`include "conv_config.svh"

module conv_top (
    input  logic                clk_i,
    input  logic                reset_i,
    input  conv_pkg::host_req_t host_req_i,
    output conv_pkg::host_rsp_t host_rsp_o
);
    import conv_pkg::*;

    conv_cfg_t                                      cfg;
    mem_port_t                                      host_mem;
    mem_port_t                                      eng_a;
    mem_port_t                                      wl_port;
    mem_port_t                                      mac_port;
    mem_port_t                                      port_b;
    tap_t                                           tap;
    logic                                           start;
    logic                                           soft_reset;
    logic                                           eng_reset;
    logic                                           busy;
    logic                                           done;
    logic [`CONV_DWIDTH-1:0]                        rdata_a;
    logic [`CONV_DWIDTH-1:0]                        rdata_b;
    logic [`CONV_WT_DIM*`CONV_WT_DIM-1:0][`CONV_DWIDTH-1:0] weights;
    logic [`CONV_WT_DIM*`CONV_WT_DIM-1:0]           wt_valid;

    assign eng_reset = reset_i || soft_reset;
    assign port_b    = wl_port.en ? wl_port : mac_port;  // loader first, then MAC writes

    conv_regs u_regs (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .host_req_i   (host_req_i),
        .host_rsp_o   (host_rsp_o),
        .mem_rdata_i  (rdata_a),
        .done_i       (done),
        .busy_i       (busy),
        .cfg_o        (cfg),
        .start_o      (start),
        .soft_reset_o (soft_reset),
        .host_mem_o   (host_mem)
    );

    conv_dmem u_dmem (
        .clk_i     (clk_i),
        .host_a_i  (host_mem),
        .eng_a_i   (eng_a),
        .busy_i    (busy),
        .port_b_i  (port_b),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b)
    );

    weight_loader u_weights (
        .clk_i      (clk_i),
        .reset_i    (eng_reset),
        .start_i    (start),
        .cfg_i      (cfg),
        .rdata_i    (rdata_b),
        .rd_port_o  (wl_port),
        .weights_o  (weights),
        .wt_valid_o (wt_valid)
    );

    window_fetch u_fetch (
        .clk_i     (clk_i),
        .reset_i   (eng_reset),
        .start_i   (start),
        .cfg_i     (cfg),
        .rdata_i   (rdata_a),
        .rd_port_o (eng_a),
        .tap_o     (tap),
        .busy_o    (busy)
    );

    conv_mac u_mac (
        .clk_i      (clk_i),
        .reset_i    (eng_reset),
        .start_i    (start),
        .cfg_i      (cfg),
        .tap_i      (tap),
        .weights_i  (weights),
        .wt_valid_i (wt_valid),
        .wr_port_o  (mac_port),
        .done_o     (done)
    );

endmodule

//--- testbench/tb_conv_top.sv
`include "conv_config.svh"

module tb_conv_top;
    timeunit 1ns;
    timeprecision 1ps;

    import conv_pkg::*;

    localparam int NTAPS      = `CONV_WT_DIM * `CONV_WT_DIM;
    localparam int NPIX       = `CONV_FM_DIM * `CONV_FM_DIM;
    localparam int POLL_LIMIT = 400;  // each poll takes two cycles

    logic                    clk;
    logic                    reset;
    host_req_t               host_req;
    host_rsp_t               host_rsp;
    logic                    exp_check;  // expected read data is valid
    logic [`CONV_DWIDTH-1:0] exp_data;
    logic [31:0]             rng_state;
    logic [`CONV_DWIDTH-1:0] wt  [2][NTAPS];
    logic [`CONV_DWIDTH-1:0] ifm [2][NPIX];

    conv_top u_dut (
        .clk_i      (clk),
        .reset_i    (reset),
        .host_req_i (host_req),
        .host_rsp_o (host_rsp)
    );

    always #4 clk = ~clk;

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Finished with errors");
        $fatal(1, "stopping at the first error");
    endtask

    // read response comes exactly one cycle after each read request
    assert property (@(posedge clk) disable iff (reset)
        host_rsp.rvalid == $past(host_req.op == HOST_READ))
        else fail_run($sformatf("FAILED at %0t ns: rvalid is %0b, read one cycle earlier was %0b",
                                $time, $sampled(host_rsp.rvalid), !$sampled(host_rsp.rvalid)));

    assert property (@(posedge clk) disable iff (reset)
        (host_req.op == HOST_READ && exp_check) |=> host_rsp.rdata == $past(exp_data))
        else fail_run($sformatf("FAILED at %0t ns: read data %h, expected %h",
                                $time, $sampled(host_rsp.rdata), $sampled(exp_data)));

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // valid 3x3 convolution, products and sum kept to the low 32 bits
    function automatic logic [`CONV_DWIDTH-1:0] conv_ref(input int run, input int r, input int c);
        logic [`CONV_DWIDTH-1:0] acc;
        acc = '0;
        for (int i = 0; i < `CONV_WT_DIM; i++) begin
            for (int j = 0; j < `CONV_WT_DIM; j++) begin
                acc += $signed(ifm[run][(r + i) * `CONV_FM_DIM + c + j])
                     * $signed(wt[run][i * `CONV_WT_DIM + j]);
            end
        end
        return acc;
    endfunction

    task automatic host_write(input logic region, input int addr, input logic [31:0] data);
        @(posedge clk);
        host_req <= '{op: HOST_WRITE, region: region, addr: `CONV_AWIDTH'(addr), wdata: data};
        @(posedge clk);
        host_req <= '{op: HOST_NOP, region: 1'b0, addr: '0, wdata: '0};
    endtask

    task automatic host_read(input logic region, input int addr, input logic check,
                             input logic [31:0] expected, output logic [31:0] data);
        @(posedge clk);
        host_req  <= '{op: HOST_READ, region: region, addr: `CONV_AWIDTH'(addr), wdata: '0};
        exp_check <= check;
        exp_data  <= expected;
        @(posedge clk);
        host_req  <= '{op: HOST_NOP, region: 1'b0, addr: '0, wdata: '0};
        exp_check <= 1'b0;
        @(negedge clk);
        data = host_rsp.rdata;  // stable between edges
    endtask

    task automatic check_read(input logic region, input int addr, input logic [31:0] expected);
        logic [31:0] unused;
        host_read(region, addr, 1'b1, expected, unused);
    endtask

    task automatic wait_done();
        logic [31:0] status;
        int          polls;
        status = '0;
        polls  = 0;
        while (!status[1] && polls < POLL_LIMIT) begin
            host_read(1'b1, `CONV_REG_STATUS, 1'b0, '0, status);
            polls++;
        end
        if (!status[1]) begin
            fail_run("timeout: the done bit in STATUS never came up");
        end
    endtask

    task automatic check_outputs(input int run, input int ofm_ofs);
        for (int r = 0; r < `CONV_OFM_DIM; r++) begin
            for (int c = 0; c < `CONV_OFM_DIM; c++) begin
                check_read(1'b0, ofm_ofs + r * `CONV_OFM_DIM + c, conv_ref(run, r, c));
            end
        end
    endtask

    task automatic run_conv(input int run, input int wt_ofs, input int ifm_ofs, input int ofm_ofs);
        for (int k = 0; k < NTAPS; k++) begin
            wt[run][k] = next_rand();
            host_write(1'b0, wt_ofs + k, wt[run][k]);
        end
        for (int k = 0; k < NPIX; k++) begin
            ifm[run][k] = next_rand();
            host_write(1'b0, ifm_ofs + k, ifm[run][k]);
        end
        for (int k = 0; k < NTAPS; k++) begin
            check_read(1'b0, wt_ofs + k, wt[run][k]);
        end
        for (int k = 0; k < NPIX; k++) begin
            check_read(1'b0, ifm_ofs + k, ifm[run][k]);
        end
        host_write(1'b1, `CONV_REG_WT_OFS, wt_ofs);
        host_write(1'b1, `CONV_REG_IFM_OFS, ifm_ofs);
        host_write(1'b1, `CONV_REG_OFM_OFS, ofm_ofs);
        check_read(1'b1, `CONV_REG_WT_OFS, wt_ofs);
        check_read(1'b1, `CONV_REG_IFM_OFS, ifm_ofs);
        check_read(1'b1, `CONV_REG_OFM_OFS, ofm_ofs);
        host_write(1'b1, `CONV_REG_CTRL, 32'h1);  // start
        wait_done();
        check_read(1'b1, `CONV_REG_STATUS, 32'h3);  // idle and done
        check_outputs(run, ofm_ofs);
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        host_req  = '{op: HOST_NOP, region: 1'b0, addr: '0, wdata: '0};
        exp_check = 1'b0;
        exp_data  = '0;
        rng_state = 32'd94092;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        check_read(1'b1, `CONV_REG_STATUS, 32'h1);  // idle, not done

        run_conv(0, 0, 16, 100);
        run_conv(1, 200, 240, 400);
        check_outputs(0, 100);  // first results must survive

        host_write(1'b1, `CONV_REG_CTRL, 32'h2);  // soft reset
        check_read(1'b1, `CONV_REG_STATUS, 32'h1);

        repeat (4) @(posedge clk);
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- sim.f
+incdir+rtl
rtl/conv_pkg.sv
rtl/conv_regs.sv
rtl/conv_dmem.sv
rtl/weight_loader.sv
rtl/window_fetch.sv
rtl/conv_mac.sv
rtl/conv_top.sv
testbench/tb_conv_top.sv

//--- Bender.yml
package:
  name: conv_accel

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/conv_pkg.sv
      - rtl/conv_regs.sv
      - rtl/conv_dmem.sv
      - rtl/weight_loader.sv
      - rtl/window_fetch.sv
      - rtl/conv_mac.sv
      - rtl/conv_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/tb_conv_top.sv
